// ==== build.f ====
logic/cpuPkg.sv
logic/alu.sv
logic/regFile.sv
logic/controlUnit.sv
logic/cpuCore.sv
logic/sysMemory.sv
logic/cpuTop.sv
dv/cpuTb.sv

// ==== dv/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb import cpuPkg::*; ();

	localparam int   CLK_PERIOD     = 4;
	localparam int   RESET_CYCLES   = 10;
	localparam int   QUIET_CYCLES   = 20;
	localparam int   NUM_WWD        = 13;
	localparam wordT EXEC_INSTRS    = 16'd41; // executed path of the program, HLT included.
	localparam int   TIMEOUT_CYCLES = RESET_CYCLES + 2 * 4 * EXEC_INSTRS + QUIET_CYCLES;

	logic Clk;
	logic rstN;
	logic wwdValid;
	wordT wwdData;
	logic halted;
	wordT numInst;

	// values in the order the program writes them out.
	wordT expectedWwd [NUM_WWD] = '{
		16'h1285, // LHI 0x12, then ORI 0x85 zero-extended.
		16'hff9c, // ADI with 0x9c sign-extended.
		16'h1221,
		16'h12e9,
		16'h1284,
		16'hff9d,
		16'hed7a,
		16'h0064,
		16'h250a,
		16'hffce, // arithmetic shift keeps the sign.
		16'hff9c, // load returns the first store.
		16'h0028, // link of JAL at 39.
		16'h002a  // link of JRL at 41.
	};

	cpuTop cpuTop_i (.Clk, .rstN, .wwdValid, .wwdData, .halted, .numInst);

	// **************************************************
	// checking
	// **************************************************
	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("FAIL: see errors above");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic checkEqual(input string name, input wordT actual, input wordT expected);
		if (actual !== expected) begin
			abortRun($sformatf("FAIL at %0d ns: %s is 0x%04h, expected 0x%04h",
				$time, name, actual, expected));
		end
	endtask

	initial begin
		Clk = 1'b0;
		forever #(CLK_PERIOD / 2) Clk = ~Clk;
	end

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		abortRun("timeout: the processor did not halt in time");
	end

	// **************************************************
	// main sequence
	// **************************************************
	initial begin
		rstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge Clk);
		#1 rstN = 1'b1;

		for (int i = 0; i < NUM_WWD; i++) begin
			@(negedge Clk); // outputs settle well before the falling edge.
			while (!wwdValid) @(negedge Clk);
			checkEqual("wwdData", wwdData, expectedWwd[i]);
		end

		while (!halted) begin
			@(negedge Clk);
			if (wwdValid) abortRun("an unexpected WWD output appeared before the halt");
		end

		// the halted core must stay silent.
		repeat (QUIET_CYCLES) begin
			@(negedge Clk);
			if (wwdValid) abortRun("a WWD output appeared after the processor halted");
		end

		checkEqual("halted", {15'd0, halted}, 16'd1);
		checkEqual("numInst", numInst, EXEC_INSTRS);
		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== dv/program.hex ====
// one instruction word per line in hex, loaded from address 0 upward.
// after each word a comment gives its decimal address and its assembly.
6112 // 00 LHI r1, 0x12
5585 // 01 ORI r1, r1, 0x85
F41C // 02 WWD r1
439C // 03 ADI r3, r0, 0x9c
FC1C // 04 WWD r3
F700 // 05 ADD r0, r1, r3
F01C // 06 WWD r0
F701 // 07 SUB r0, r1, r3
F01C // 08 WWD r0
F702 // 09 AND r0, r1, r3
F01C // 10 WWD r0
F703 // 11 ORR r0, r1, r3
F01C // 12 WWD r0
F404 // 13 NOT r0, r1
F01C // 14 WWD r0
FC05 // 15 TCP r0, r3
F01C // 16 WWD r0
F406 // 17 SHL r0, r1
F01C // 18 WWD r0
FC07 // 19 SHR r0, r3
F01C // 20 WWD r0
873B // 21 SWD r3, [r1 + 0x3b]
843C // 22 SWD r0, [r1 + 0x3c]
743B // 23 LWD r0, [r1 + 0x3b]
F01C // 24 WWD r0
0301 // 25 BNE r0, r3, +1 (not taken)
1301 // 26 BEQ r0, r3, +1 (taken)
F41C // 27 WWD r1 (skipped)
1101 // 28 BEQ r0, r1, +1 (not taken)
0101 // 29 BNE r0, r1, +1 (taken)
F41C // 30 WWD r1 (skipped)
2801 // 31 BGZ r2, +1 (not taken, r2 is zero)
3001 // 32 BLZ r0, +1 (taken)
F41C // 33 WWD r1 (skipped)
3401 // 34 BLZ r1, +1 (not taken)
2401 // 35 BGZ r1, +1 (taken)
F41C // 36 WWD r1 (skipped)
9027 // 37 JMP 39
F41C // 38 WWD r1 (skipped)
A02A // 39 JAL 42
4B04 // 40 ADI r3, r2, 4
FC1A // 41 JRL r3
F81C // 42 WWD r2
F819 // 43 JPR r2
F81C // 44 WWD r2
F01D // 45 HLT

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu import cpuPkg::*; (
	input  aluOpT op,
	input  wordT  a,
	input  wordT  b,
	output wordT  result,
	output logic  zeroEq,
	output logic  aPos,
	output logic  aNeg
);

	always_comb begin
		case (op)
			ADD:     result = a + b;
			SUB:     result = a - b;
			AND:     result = a & b;
			ORR:     result = a | b;
			NOT:     result = ~a;
			TCP:     result = ~a + 16'd1;
			SHL:     result = {a[WORD_W-2:0], 1'b0};
			SHR:     result = {a[WORD_W-1], a[WORD_W-1:1]}; // keeps the sign.
			default: result = '0;
		endcase
	end

	// **************************************************
	// branch conditions
	// **************************************************
	assign zeroEq = (a == b);
	assign aNeg   = a[WORD_W-1];
	assign aPos   = !a[WORD_W-1] && (a != '0);

endmodule

// ==== logic/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit import cpuPkg::*; (
	input  logic     Clk,
	input  logic     rstN,
	input  wordT     instr,
	output ctrlWordT ctrl,
	output cpuStateT state
);

	cpuStateT nextState;

	// control word of a register to register ALU operation.
	function automatic ctrlWordT rType(aluOpT op);
		ctrlWordT c;
		c          = '0;
		c.regWrite = 1'b1;
		c.aluOp    = op;
		c.destSel  = RD;
		return c;
	endfunction

	function automatic ctrlWordT decodeInstr(wordT ins);
		ctrlWordT c;
		opcodeT   opcode;
		funcT     func;
		opcode = ins[15:12];
		func   = ins[5:0];
		c      = '0; // unknown encodings fall through as a no-op.
		if (opcode == JPR_OP && func == FN_JPR) begin
			c.isJumpReg = 1'b1;
		end else if (opcode == JRL_OP && func == FN_JRL) begin
			c.isJumpReg = 1'b1;
			c.isLink    = 1'b1;
			c.regWrite  = 1'b1;
			c.destSel   = LINK;
		end else begin
			case (opcode)
				ALU_OP: begin
					case (func)
						FN_ADD: c = rType(ADD);
						FN_SUB: c = rType(SUB);
						FN_AND: c = rType(AND);
						FN_ORR: c = rType(ORR);
						FN_NOT: c = rType(NOT);
						FN_TCP: c = rType(TCP);
						FN_SHL: c = rType(SHL);
						FN_SHR: c = rType(SHR);
						FN_WWD: c.isWwd = 1'b1;
						FN_HLT: c.isHalt = 1'b1;
						default: c = '0;
					endcase
				end
				ADI_OP, ORI_OP, LHI_OP: begin
					c.regWrite  = 1'b1;
					c.aluSrcImm = 1'b1;
					c.destSel   = RT;
					c.aluOp     = (opcode == ADI_OP) ? ADD : ORR;
					c.immKind   = (opcode == ADI_OP) ? SIGNEXT :
						(opcode == ORI_OP) ? ZEROEXT : UPPER;
				end
				LWD_OP: begin
					c.regWrite  = 1'b1;
					c.aluSrcImm = 1'b1;
					c.memRead   = 1'b1;
					c.memToReg  = 1'b1;
					c.destSel   = RT;
				end
				SWD_OP: begin
					c.aluSrcImm = 1'b1;
					c.memWrite  = 1'b1;
				end
				BNE_OP, BEQ_OP, BGZ_OP, BLZ_OP: begin
					c.isBranch = 1'b1; // compares rs with rt.
					c.aluOp    = SUB;
				end
				JMP_OP: c.isJump = 1'b1;
				JAL_OP: begin
					c.isJump   = 1'b1;
					c.isLink   = 1'b1;
					c.regWrite = 1'b1;
					c.destSel  = LINK;
				end
				default: c = '0;
			endcase
		end
		return c;
	endfunction

	always_comb begin
		case (state)
			FETCH:   nextState = DECODE;
			DECODE:  nextState = EXECUTE;
			EXECUTE: begin
				if (ctrl.memRead) nextState = MEMWB;
				else if (ctrl.isHalt) nextState = HALTED;
				else nextState = FETCH;
			end
			MEMWB:   nextState = FETCH;
			default: nextState = HALTED;
		endcase
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			state <= FETCH;
			ctrl  <= '0;
		end else begin
			state <= nextState;
			if (state == DECODE) ctrl <= decodeInstr(instr); // instr is the word just read.
		end
	end

endmodule

// ==== logic/cpuCore.sv ====
`timescale 1ns/1ps

module cpuCore import cpuPkg::*; (
	input  logic    Clk,
	input  logic    rstN,
	output memAddrT memAddr,
	output logic    memRead,
	output logic    memWrite,
	output wordT    memWData,
	input  wordT    memRData,
	output logic    wwdValid,
	output wordT    wwdData,
	output logic    halted,
	output wordT    numInst
);

	ctrlWordT ctrl;
	cpuStateT state;
	wordT     pc;
	wordT     pcPlus1;
	wordT     ir;
	wordT     immSext;
	wordT     immValue;
	wordT     branchTarget;
	wordT     jumpTarget;
	wordT     nextPc;
	wordT     rData1;
	wordT     rData2;
	wordT     aluA;
	wordT     aluB;
	wordT     aluResult;
	wordT     wData;
	regAddrT  wAddr;
	logic     wEn;
	logic     zeroEq;
	logic     aPos;
	logic     aNeg;
	logic     branchTaken;
	opcodeT   opcode;

	controlUnit controlUnit_i (.Clk, .rstN, .instr(memRData), .ctrl, .state);

	regFile regFile_i (
		.Clk, .rstN,
		.rAddr1(ir[11:10]), .rAddr2(ir[9:8]), .wAddr,
		.wEn, .wData, .rData1, .rData2
	);

	alu alu_i (
		.op(ctrl.aluOp), .a(aluA), .b(aluB), .result(aluResult),
		.zeroEq, .aPos, .aNeg
	);

	// **************************************************
	// fetch and immediates
	// **************************************************
	always_ff @(posedge Clk) begin
		if (state == DECODE) ir <= memRData;
	end

	assign opcode  = ir[15:12];
	assign immSext = {{8{ir[7]}}, ir[7:0]};

	always_comb begin
		case (ctrl.immKind)
			ZEROEXT: immValue = {8'd0, ir[7:0]};
			UPPER:   immValue = {ir[7:0], 8'd0};
			default: immValue = immSext;
		endcase
	end

	// LHI passes the shifted immediate through the ALU unchanged.
	assign aluA = (ctrl.immKind == UPPER) ? '0 : rData1;
	assign aluB = ctrl.aluSrcImm ? immValue : rData2;

	// **************************************************
	// next PC
	// **************************************************
	assign pcPlus1      = pc + 16'd1;
	assign branchTarget = pcPlus1 + immSext;
	assign jumpTarget   = {pc[15:12], ir[11:0]};

	always_comb begin
		branchTaken = 1'b0;
		if (ctrl.isBranch) begin
			case (opcode)
				BNE_OP:  branchTaken = !zeroEq;
				BEQ_OP:  branchTaken = zeroEq;
				BGZ_OP:  branchTaken = aPos;
				BLZ_OP:  branchTaken = aNeg;
				default: branchTaken = 1'b0;
			endcase
		end
	end

	always_comb begin
		if (ctrl.isJumpReg) nextPc = rData1;
		else if (ctrl.isJump) nextPc = jumpTarget;
		else if (branchTaken) nextPc = branchTarget;
		else nextPc = pcPlus1;
	end

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) pc <= '0;
		else if (state == EXECUTE) pc <= nextPc;
	end

	// **************************************************
	// memory and writeback
	// **************************************************
	assign memAddr  = (state == EXECUTE) ? aluResult[MEM_ADDR_W-1:0] : pc[MEM_ADDR_W-1:0];
	assign memRead  = (state == FETCH) || (state == EXECUTE && ctrl.memRead);
	assign memWrite = (state == EXECUTE) && ctrl.memWrite;
	assign memWData = rData2;

	// a load writes rt one cycle late, in MEMWB.
	assign wEn = (state == EXECUTE && ctrl.regWrite && !ctrl.memRead) ||
		(state == MEMWB && ctrl.memToReg);

	always_comb begin
		case (ctrl.destSel)
			RT:      wAddr = ir[9:8];
			LINK:    wAddr = LINK_REG;
			default: wAddr = ir[7:6];
		endcase
	end

	assign wData = ctrl.memToReg ? memRData : ctrl.isLink ? pcPlus1 : aluResult;

	// **************************************************
	// outputs
	// **************************************************
	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			wwdValid <= 1'b0;
			numInst  <= '0;
		end else begin
			wwdValid <= (state == EXECUTE) && ctrl.isWwd;
			if ((state == EXECUTE && !ctrl.memRead) || state == MEMWB) begin
				numInst <= numInst + 16'd1; // counts HLT as well.
			end
		end
	end

	always_ff @(posedge Clk) begin
		if (state == EXECUTE && ctrl.isWwd) wwdData <= rData1;
	end

	assign halted = (state == HALTED);

endmodule

// ==== logic/cpuPkg.sv ====
package cpuPkg;

	// **************************************************
	// widths
	// **************************************************
	localparam int WORD_W     = 16;
	localparam int REG_ADDR_W = 2;
	localparam int NUM_REGS   = 2 ** REG_ADDR_W;
	localparam int MEM_ADDR_W = 8;
	localparam int MEM_WORDS  = 256;
	localparam int OPCODE_W   = 4;
	localparam int FUNC_W     = 6;

	typedef logic [WORD_W-1:0]     wordT;
	typedef logic [REG_ADDR_W-1:0] regAddrT;
	typedef logic [MEM_ADDR_W-1:0] memAddrT;
	typedef logic [OPCODE_W-1:0]   opcodeT;
	typedef logic [FUNC_W-1:0]     funcT;

	localparam regAddrT LINK_REG = 2'd2; // JAL and JRL leave the return address here.

	// **************************************************
	// opcodes and function codes
	// **************************************************
	localparam opcodeT BNE_OP = 4'd0;
	localparam opcodeT BEQ_OP = 4'd1;
	localparam opcodeT BGZ_OP = 4'd2;
	localparam opcodeT BLZ_OP = 4'd3;
	localparam opcodeT ADI_OP = 4'd4;
	localparam opcodeT ORI_OP = 4'd5;
	localparam opcodeT LHI_OP = 4'd6;
	localparam opcodeT LWD_OP = 4'd7;
	localparam opcodeT SWD_OP = 4'd8;
	localparam opcodeT JMP_OP = 4'd9;
	localparam opcodeT JAL_OP = 4'd10;
	localparam opcodeT ALU_OP = 4'd15;
	localparam opcodeT JPR_OP = 4'd15; // shares the R-type opcode.
	localparam opcodeT JRL_OP = 4'd15;

	localparam funcT FN_ADD = 6'd0;
	localparam funcT FN_SUB = 6'd1;
	localparam funcT FN_AND = 6'd2;
	localparam funcT FN_ORR = 6'd3;
	localparam funcT FN_NOT = 6'd4;
	localparam funcT FN_TCP = 6'd5;
	localparam funcT FN_SHL = 6'd6;
	localparam funcT FN_SHR = 6'd7;
	localparam funcT FN_JPR = 6'd25;
	localparam funcT FN_JRL = 6'd26;
	localparam funcT FN_WWD = 6'd28;
	localparam funcT FN_HLT = 6'd29;

	// **************************************************
	// control types
	// **************************************************
	typedef enum logic [2:0] {
		ADD, SUB, AND, ORR, NOT, TCP, SHL, SHR
	} aluOpT;

	typedef enum logic [1:0] {
		SIGNEXT,
		ZEROEXT,
		UPPER
	} immKindT;

	typedef enum logic [1:0] {
		RD,
		RT,
		LINK
	} destSelT;

	typedef struct packed {
		logic    regWrite;
		logic    aluSrcImm; // second ALU operand is the immediate, not rt.
		logic    memWrite;
		logic    memRead;
		logic    memToReg;
		logic    isBranch;
		logic    isJump;
		logic    isJumpReg;
		logic    isLink;
		logic    isWwd;
		logic    isHalt;
		aluOpT   aluOp;
		immKindT immKind;
		destSelT destSel;
	} ctrlWordT;

	typedef enum logic [2:0] {
		FETCH,
		DECODE,
		EXECUTE,
		MEMWB,
		HALTED
	} cpuStateT;

endpackage

// ==== logic/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop import cpuPkg::*; (
	input  logic Clk,
	input  logic rstN,
	output logic wwdValid,
	output wordT wwdData,
	output logic halted,
	output wordT numInst
);

	memAddrT memAddr;
	logic    memRead;
	logic    memWrite;
	wordT    memWData;
	wordT    memRData;

	cpuCore cpuCore_i (
		.Clk, .rstN,
		.memAddr, .memRead, .memWrite, .memWData, .memRData,
		.wwdValid, .wwdData, .halted, .numInst
	);

	sysMemory sysMemory_i (
		.Clk, .addr(memAddr), .rdEn(memRead), .wrEn(memWrite),
		.wData(memWData), .rData(memRData)
	);

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/1ps

module regFile import cpuPkg::*; (
	input  logic    Clk,
	input  logic    rstN,
	input  regAddrT rAddr1,
	input  regAddrT rAddr2,
	input  regAddrT wAddr,
	input  logic    wEn,
	input  wordT    wData,
	output wordT    rData1,
	output wordT    rData2
);

	wordT regs [NUM_REGS];

	always_ff @(posedge Clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wEn) begin
			regs[wAddr] <= wData;
		end
	end

	// reads see the old value during the write cycle.
	assign rData1 = regs[rAddr1];
	assign rData2 = regs[rAddr2];

endmodule

// ==== logic/sysMemory.sv ====
`timescale 1ns/1ps

module sysMemory import cpuPkg::*; (
	input  logic    Clk,
	input  memAddrT addr,
	input  logic    rdEn,
	input  logic    wrEn,
	input  wordT    wData,
	output wordT    rData
);

	wordT mem [MEM_WORDS];

	// program and data share this one array.
	initial begin
		$readmemh("dv/program.hex", mem);
	end

	always_ff @(posedge Clk) begin
		if (wrEn) mem[addr] <= wData;
		if (rdEn) rData <= mem[addr]; // holds its value while rdEn is low.
	end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build with Verilator, run from the project root, then search the log for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module cpuTb -f build.f -o cpuSim \
	&& { ./obj_dir/cpuSim > sim.log 2>&1 || true; } \
	&& cat sim.log \
	&& grep -qx "PASS: all tests" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
